// File: logic/rv_exec_pkg.sv
`default_nettype none

package rv_exec_pkg;

  localparam int XLEN = 32;
  localparam int DIV_STEPS = 32;
  localparam int DIV_CNT_W = $clog2(DIV_STEPS + 1);

  localparam logic [11:0] CSR_MSTATUS = 12'h300;
  localparam logic [11:0] CSR_MEPC = 12'h341;
  localparam logic [11:0] CSR_SSTATUS = 12'h100;
  localparam logic [11:0] CSR_SEPC = 12'h141;

  // Numbering matches the decoder
  typedef enum logic [5:0] {
    OP_ADD = 6'd0, OP_SUB, OP_SLL, OP_SLT, OP_SLTU,
    OP_XOR, OP_SRL, OP_SRA, OP_OR, OP_AND,
    OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU,
    OP_DIV, OP_DIVU, OP_REM, OP_REMU,
    OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI, OP_ANDI,
    OP_SLLI, OP_SRLI, OP_SRAI,
    OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU,
    OP_SB, OP_SH, OP_SW,
    OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
    OP_JAL, OP_JALR, OP_LUI, OP_AUIPC,
    OP_CSRRW, OP_CSRRS, OP_CSRRC, OP_CSRRWI, OP_CSRRSI, OP_CSRRCI,
    OP_FENCE, OP_FENCE_I, OP_ECALL, OP_EBREAK,
    OP_URET, OP_SRET, OP_MRET, OP_WFI, OP_SFENCE_VMA
  } exec_op_e;

  typedef enum logic [1:0] {
    ST_FETCH,
    ST_EXECUTE,
    ST_MINT,
    ST_SINT
  } stage_e;

  typedef enum logic [1:0] {
    MODE_USER = 2'b00,
    MODE_SUPERVISOR = 2'b01,
    MODE_MACHINE = 2'b11
  } priv_mode_e;

  typedef struct packed {
    exec_op_e op;
    logic [XLEN-1:0] ir;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] pc;
  } exec_req_t;

  typedef struct packed {
    logic wr;
    logic [11:0] sel;
    logic [XLEN-1:0] data;
  } csr_wr_t;

  typedef struct packed {
    logic valid;
    logic [XLEN-1:0] addr;
  } redirect_t;

  typedef struct packed {
    logic [XLEN-1:0] mstatus;
    logic [XLEN-1:0] sstatus;
    logic [XLEN-1:0] mtvec;
    logic [XLEN-1:0] stvec;
  } trap_csrs_t;

endpackage

`default_nettype wire

// File: logic/int_alu.sv
`timescale 1ns/10ps
`default_nettype none

module int_alu (
  input wire rv_exec_pkg::exec_req_t i_req,
  input wire [rv_exec_pkg::XLEN-1:0] i_csr_rdata,
  output logic [rv_exec_pkg::XLEN-1:0] o_result,
  output logic o_result_wr,
  output rv_exec_pkg::redirect_t o_redirect,
  output rv_exec_pkg::csr_wr_t o_csr,
  input wire i_active
);
  import rv_exec_pkg::*;

  logic [XLEN-1:0] a, b, pc, ir;
  logic [XLEN-1:0] imm_i, imm_b, imm_j, imm_u, imm_csr;
  logic [2*XLEN-1:0] prod_ss, prod_su, prod_uu;
  logic [XLEN-1:0] target, csr_data;
  logic rd_en, jump, csr_en;
  logic eq, lt, ltu;

  assign a = i_req.a;
  assign b = i_req.b;
  assign pc = i_req.pc;
  assign ir = i_req.ir;

  assign imm_i = {{(XLEN-12){ir[31]}}, ir[31:20]};
  assign imm_b = {{(XLEN-12){ir[31]}}, ir[7], ir[30:25], ir[11:8], 1'b0};
  assign imm_j = {{(XLEN-20){ir[31]}}, ir[19:12], ir[20], ir[30:21], 1'b0};
  assign imm_u = {ir[31:12], 12'b0};
  assign imm_csr = {{(XLEN-5){1'b0}}, ir[19:15]}; // zimm field

  // Operands extended to 64 bits so the low product half stays exact
  assign prod_ss = {{XLEN{a[XLEN-1]}}, a} * {{XLEN{b[XLEN-1]}}, b};
  assign prod_su = {{XLEN{a[XLEN-1]}}, a} * {{XLEN{1'b0}}, b};
  assign prod_uu = {{XLEN{1'b0}}, a} * {{XLEN{1'b0}}, b};

  assign eq = (a == b);
  assign lt = ($signed(a) < $signed(b));
  assign ltu = (a < b);

  always_comb begin
    o_result = '0;
    rd_en = 1'b0;
    jump = 1'b0;
    csr_en = 1'b0;
    csr_data = '0;
    target = pc + imm_b;
    case (i_req.op)
      OP_ADD: o_result = a + b;
      OP_SUB: o_result = a - b;
      OP_SLL: o_result = a << b[4:0];
      OP_SLT: o_result = {{(XLEN-1){1'b0}}, lt};
      OP_SLTU: o_result = {{(XLEN-1){1'b0}}, ltu};
      OP_XOR: o_result = a ^ b;
      OP_SRL: o_result = a >> b[4:0];
      OP_SRA: o_result = $signed(a) >>> b[4:0];
      OP_OR: o_result = a | b;
      OP_AND: o_result = a & b;
      OP_MUL: o_result = prod_ss[XLEN-1:0];
      OP_MULH: o_result = prod_ss[2*XLEN-1:XLEN];
      OP_MULHSU: o_result = prod_su[2*XLEN-1:XLEN];
      OP_MULHU: o_result = prod_uu[2*XLEN-1:XLEN];
      OP_ADDI: o_result = a + imm_i;
      OP_SLTI: o_result = {{(XLEN-1){1'b0}}, $signed(a) < $signed(imm_i)};
      OP_SLTIU: o_result = {{(XLEN-1){1'b0}}, a < imm_i};
      OP_XORI: o_result = a ^ imm_i;
      OP_ORI: o_result = a | imm_i;
      OP_ANDI: o_result = a & imm_i;
      OP_SLLI: o_result = a << ir[24:20];
      OP_SRLI: o_result = a >> ir[24:20];
      OP_SRAI: o_result = $signed(a) >>> ir[24:20];
      OP_BEQ: jump = eq;
      OP_BNE: jump = !eq;
      OP_BLT: jump = lt;
      OP_BGE: jump = !lt;
      OP_BLTU: jump = ltu;
      OP_BGEU: jump = !ltu;
      OP_JAL: begin
        jump = 1'b1;
        target = pc + imm_j;
        o_result = pc + 32'd4; // Link address
      end
      OP_JALR: begin
        jump = 1'b1;
        target = a + imm_i;
        o_result = pc + 32'd4;
      end
      OP_LUI: o_result = imm_u;
      OP_AUIPC: o_result = pc + imm_u;
      OP_CSRRW: csr_data = a;
      OP_CSRRS: csr_data = i_csr_rdata | a;
      OP_CSRRC: csr_data = i_csr_rdata & ~a;
      OP_CSRRWI: csr_data = imm_csr;
      OP_CSRRSI: csr_data = i_csr_rdata | imm_csr;
      OP_CSRRCI: csr_data = i_csr_rdata & ~imm_csr;
      default: ; // Memory, system ops and division handled elsewhere
    endcase

    case (i_req.op)
      OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU, OP_XOR, OP_SRL, OP_SRA, OP_OR, OP_AND,
      OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU,
      OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI, OP_ANDI, OP_SLLI, OP_SRLI, OP_SRAI,
      OP_JAL, OP_JALR, OP_LUI, OP_AUIPC: rd_en = 1'b1;
      OP_CSRRW, OP_CSRRS, OP_CSRRC, OP_CSRRWI, OP_CSRRSI, OP_CSRRCI: begin
        rd_en = 1'b1;
        csr_en = 1'b1;
        o_result = i_csr_rdata; // Old value goes to rd
      end
      default: ;
    endcase
  end

  assign o_result_wr = i_active & rd_en;
  assign o_redirect = '{valid: i_active & jump, addr: target};
  assign o_csr = '{wr: i_active & csr_en, sel: ir[31:20], data: csr_data};

endmodule

`default_nettype wire

// File: logic/seq_divider.sv
`timescale 1ns/10ps
`default_nettype none

module seq_divider (
  input wire i_clk,
  input wire i_rst_n,
  input wire i_start,
  input wire i_signed,
  input wire [rv_exec_pkg::XLEN-1:0] i_dividend,
  input wire [rv_exec_pkg::XLEN-1:0] i_divisor,
  output logic o_done,
  output logic [rv_exec_pkg::XLEN-1:0] o_quotient,
  output logic [rv_exec_pkg::XLEN-1:0] o_remainder
);
  import rv_exec_pkg::*;

  logic busy_q;
  logic [DIV_CNT_W-1:0] cnt_q;
  logic [XLEN-1:0] quo_q, rem_q, dsor_q, dividend_q;
  logic neg_quo_q, neg_rem_q, zero_q;
  logic dvd_neg, dsr_neg;
  logic [XLEN-1:0] dvd_mag, dsr_mag;
  logic [XLEN:0] trial;

  assign dvd_neg = i_signed & i_dividend[XLEN-1];
  assign dsr_neg = i_signed & i_divisor[XLEN-1];
  assign dvd_mag = dvd_neg ? -i_dividend : i_dividend;
  assign dsr_mag = dsr_neg ? -i_divisor : i_divisor;

  // Shift in next dividend bit and try to subtract
  assign trial = {rem_q, quo_q[XLEN-1]} - {1'b0, dsor_q};

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      busy_q <= 1'b0;
      cnt_q <= '0;
      o_done <= 1'b0;
    end else begin
      o_done <= 1'b0;
      if (busy_q) begin
        cnt_q <= cnt_q - 1'b1;
        if (cnt_q == DIV_CNT_W'(1)) begin
          busy_q <= 1'b0;
          o_done <= 1'b1; // Last step lands this edge
        end
      end else if (i_start) begin
        busy_q <= 1'b1;
        cnt_q <= DIV_CNT_W'(DIV_STEPS);
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (!busy_q && i_start) begin
      quo_q <= dvd_mag;
      rem_q <= '0;
      dsor_q <= dsr_mag;
      dividend_q <= i_dividend;
      neg_quo_q <= dvd_neg ^ dsr_neg;
      neg_rem_q <= dvd_neg; // Remainder takes dividend sign
      zero_q <= (i_divisor == '0);
    end else if (busy_q) begin
      if (!trial[XLEN]) begin
        rem_q <= trial[XLEN-1:0];
        quo_q <= {quo_q[XLEN-2:0], 1'b1};
      end else begin
        rem_q <= {rem_q[XLEN-2:0], quo_q[XLEN-1]};
        quo_q <= {quo_q[XLEN-2:0], 1'b0};
      end
    end
  end

  // Overflow magnitude 2^31 already has the expected bit pattern
  assign o_quotient = zero_q ? '1 : (neg_quo_q ? -quo_q : quo_q);
  assign o_remainder = zero_q ? dividend_q : (neg_rem_q ? -rem_q : rem_q);

endmodule

`default_nettype wire

// File: logic/trap_entry.sv
`timescale 1ns/10ps
`default_nettype none

module trap_entry (
  input wire i_clk,
  input wire i_rst_n,
  input wire rv_exec_pkg::stage_e i_stage,
  input wire [rv_exec_pkg::XLEN-1:0] i_pc,
  input wire rv_exec_pkg::trap_csrs_t i_trap_csrs,
  output rv_exec_pkg::csr_wr_t o_csr,
  output rv_exec_pkg::redirect_t o_redirect,
  output logic o_done
);
  import rv_exec_pkg::*;

  typedef enum logic [1:0] {TS_IDLE, TS_STATUS, TS_EPC, TS_HOLD} trap_state_e;

  trap_state_e state_q;
  priv_mode_e mode_q;
  logic is_m_q;
  logic in_trap;
  logic [XLEN-1:0] mstatus_nxt, sstatus_nxt;

  assign in_trap = (i_stage == ST_MINT) || (i_stage == ST_SINT);

  always_comb begin
    mstatus_nxt = i_trap_csrs.mstatus;
    mstatus_nxt[12:11] = mode_q; // MPP
    mstatus_nxt[7] = i_trap_csrs.mstatus[3]; // MPIE
    mstatus_nxt[3] = 1'b0;
    sstatus_nxt = i_trap_csrs.sstatus;
    sstatus_nxt[8] = mode_q[0]; // SPP
    sstatus_nxt[5] = i_trap_csrs.sstatus[1]; // SPIE
    sstatus_nxt[1] = 1'b0;
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      state_q <= TS_IDLE;
      mode_q <= MODE_MACHINE;
      o_csr.wr <= 1'b0;
      o_redirect.valid <= 1'b0;
      o_done <= 1'b0;
    end else begin
      o_csr.wr <= 1'b0;
      o_redirect.valid <= 1'b0;
      o_done <= 1'b0;
      case (state_q)
        TS_IDLE: if (in_trap) begin
          is_m_q <= (i_stage == ST_MINT);
          o_csr <= (i_stage == ST_MINT) ? '{1'b1, CSR_MSTATUS, mstatus_nxt}
                                         : '{1'b1, CSR_SSTATUS, sstatus_nxt};
          state_q <= TS_STATUS;
        end
        TS_STATUS: begin
          o_csr <= '{1'b1, is_m_q ? CSR_MEPC : CSR_SEPC, i_pc};
          o_redirect <= '{1'b1, is_m_q ? i_trap_csrs.mtvec : i_trap_csrs.stvec};
          o_done <= 1'b1;
          mode_q <= is_m_q ? MODE_MACHINE : MODE_SUPERVISOR;
          state_q <= TS_EPC;
        end
        TS_EPC: state_q <= in_trap ? TS_HOLD : TS_IDLE;
        default: if (!in_trap) state_q <= TS_IDLE; // Wait for stage to move on
      endcase
    end
  end

endmodule

`default_nettype wire

// File: logic/exec_unit.sv
`timescale 1ns/10ps
`default_nettype none

module exec_unit (
  input wire i_clk,
  input wire i_rst_n,
  input wire rv_exec_pkg::stage_e i_stage,
  input wire rv_exec_pkg::exec_req_t i_req,
  input wire [rv_exec_pkg::XLEN-1:0] i_csr_rdata,
  input wire rv_exec_pkg::trap_csrs_t i_trap_csrs,
  output logic o_rd_wr,
  output logic [rv_exec_pkg::XLEN-1:0] o_rd_data,
  output rv_exec_pkg::redirect_t o_redirect,
  output rv_exec_pkg::csr_wr_t o_csr,
  output logic o_trap_done
);
  import rv_exec_pkg::*;

  logic active, in_trap;
  logic is_div_op, div_signed, div_start, div_busy_q;
  logic div_done;
  logic [XLEN-1:0] div_quo, div_rem, div_result;
  logic [XLEN-1:0] alu_result;
  logic alu_wr;
  redirect_t alu_redirect, trap_redirect;
  csr_wr_t alu_csr, trap_csr;
  logic trap_done;

  assign active = (i_stage == ST_EXECUTE);
  assign in_trap = (i_stage == ST_MINT) || (i_stage == ST_SINT);

  assign is_div_op = (i_req.op == OP_DIV) || (i_req.op == OP_DIVU) ||
                     (i_req.op == OP_REM) || (i_req.op == OP_REMU);
  assign div_signed = (i_req.op == OP_DIV) || (i_req.op == OP_REM);
  assign div_start = active & is_div_op & !div_busy_q; // First cycle only

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      div_busy_q <= 1'b0;
    end else if (div_done) begin
      div_busy_q <= 1'b0;
    end else if (div_start) begin
      div_busy_q <= 1'b1;
    end
  end

  int_alu alu_i (
    .i_req(i_req),
    .i_csr_rdata(i_csr_rdata),
    .o_result(alu_result),
    .o_result_wr(alu_wr),
    .o_redirect(alu_redirect),
    .o_csr(alu_csr),
    .i_active(active)
  );

  seq_divider div_i (
    .i_clk(i_clk),
    .i_rst_n(i_rst_n),
    .i_start(div_start),
    .i_signed(div_signed),
    .i_dividend(i_req.a),
    .i_divisor(i_req.b),
    .o_done(div_done),
    .o_quotient(div_quo),
    .o_remainder(div_rem)
  );

  trap_entry trap_i (
    .i_clk(i_clk),
    .i_rst_n(i_rst_n),
    .i_stage(i_stage),
    .i_pc(i_req.pc),
    .i_trap_csrs(i_trap_csrs),
    .o_csr(trap_csr),
    .o_redirect(trap_redirect),
    .o_done(trap_done)
  );

  assign div_result = ((i_req.op == OP_DIV) || (i_req.op == OP_DIVU)) ? div_quo : div_rem;

  assign o_rd_wr = alu_wr | (active & is_div_op & div_done);
  assign o_rd_data = is_div_op ? div_result : alu_result;
  assign o_redirect = in_trap ? trap_redirect : alu_redirect;
  assign o_csr = in_trap ? trap_csr : alu_csr;
  assign o_trap_done = in_trap & trap_done;

endmodule

`default_nettype wire

// File: sim/exec_unit_asserts.sv
`timescale 1ns/10ps
`default_nettype none

module exec_unit_asserts (
  input wire i_clk,
  input wire i_rst_n,
  input wire rv_exec_pkg::stage_e i_stage,
  input wire i_rd_wr,
  input wire rv_exec_pkg::redirect_t i_redirect,
  input wire rv_exec_pkg::csr_wr_t i_csr,
  input wire i_trap_done
);
  import rv_exec_pkg::*;

  logic in_trap, status_wr, epc_wr;

  assign in_trap = (i_stage == ST_MINT) || (i_stage == ST_SINT);
  assign status_wr = in_trap && i_csr.wr && (i_csr.sel inside {CSR_MSTATUS, CSR_SSTATUS});
  assign epc_wr = i_csr.wr && (i_csr.sel inside {CSR_MEPC, CSR_SEPC});

  done_redirects: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_trap_done |-> i_redirect.valid) else $error("trap done without a redirect");

  status_then_epc: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    status_wr |=> epc_wr) else $error("status write not followed by an EPC write");

  fetch_quiet: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (i_stage == ST_FETCH) |-> !(i_rd_wr || i_redirect.valid || i_csr.wr || i_trap_done))
    else $error("strobe raised during FETCH");

endmodule

`default_nettype wire

// File: sim/exec_unit_tb.sv
`timescale 1ns/10ps
`default_nettype none

module exec_unit_tb;
  import rv_exec_pkg::*;

  typedef struct packed {
    logic rd_wr;
    logic [XLEN-1:0] rd;
    redirect_t redirect;
    csr_wr_t csr;
    logic trap_done;
  } exec_exp_t;

  localparam int WAIT_LIMIT = 100;

  logic clk, rst_n;
  stage_e stage;
  exec_req_t req;
  logic [XLEN-1:0] csr_rdata;
  trap_csrs_t trap_csrs;
  logic rd_wr, trap_done;
  logic [XLEN-1:0] rd_data;
  redirect_t redirect;
  csr_wr_t csr;

  logic [31:0] lfsr_q;
  int err_cnt, timeout_cnt;
  exec_exp_t exp_q;
  string test_name;
  event cmp_ev;
  priv_mode_e tb_mode;

  exec_unit dut_i (
    .i_clk(clk),
    .i_rst_n(rst_n),
    .i_stage(stage),
    .i_req(req),
    .i_csr_rdata(csr_rdata),
    .i_trap_csrs(trap_csrs),
    .o_rd_wr(rd_wr),
    .o_rd_data(rd_data),
    .o_redirect(redirect),
    .o_csr(csr),
    .o_trap_done(trap_done)
  );

  bind exec_unit exec_unit_asserts asserts_i (
    .i_clk(i_clk),
    .i_rst_n(i_rst_n),
    .i_stage(i_stage),
    .i_rd_wr(o_rd_wr),
    .i_redirect(o_redirect),
    .i_csr(o_csr),
    .i_trap_done(o_trap_done)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Galois form of x^32+x^22+x^2+x+1
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      v = {v[30:0], lfsr_q[0]};
      lfsr_q = (lfsr_q >> 1) ^ (lfsr_q[0] ? 32'h8020_0003 : 32'h0);
    end
    return v;
  endfunction

  function automatic logic [XLEN-1:0] div_model(input exec_req_t r);
    logic sgn;
    logic [XLEN-1:0] q, m;
    sgn = (r.op == OP_DIV) || (r.op == OP_REM);
    if (r.b == '0) begin
      q = '1;
      m = r.a;
    end else if (sgn && r.a == 32'h8000_0000 && r.b == '1) begin
      q = r.a; // Signed overflow
      m = '0;
    end else if (sgn) begin
      q = $signed(r.a) / $signed(r.b);
      m = $signed(r.a) % $signed(r.b);
    end else begin
      q = r.a / r.b;
      m = r.a % r.b;
    end
    return (r.op == OP_DIV || r.op == OP_DIVU) ? q : m;
  endfunction

  function automatic exec_exp_t exec_model(input exec_req_t r, input logic [XLEN-1:0] old);
    exec_exp_t e;
    logic [XLEN-1:0] imm_i, imm_j, imm_u, zimm;
    logic [63:0] p_ss, p_su, p_uu;
    logic [4:0] sh;
    e = '0;
    imm_i = 32'($signed(r.ir[31:20]));
    imm_j = 32'($signed({r.ir[31], r.ir[19:12], r.ir[20], r.ir[30:21], 1'b0}));
    imm_u = {r.ir[31:12], 12'h000};
    zimm = 32'(r.ir[19:15]);
    p_ss = longint'($signed(r.a)) * longint'($signed(r.b));
    p_su = longint'($signed(r.a)) * longint'({32'h0, r.b});
    p_uu = {32'h0, r.a} * {32'h0, r.b};
    sh = (r.op inside {[OP_SLLI:OP_SRAI]}) ? r.ir[24:20] : r.b[4:0];
    e.rd_wr = !(r.op inside {[OP_LB:OP_BGEU], [OP_FENCE:OP_SFENCE_VMA]});
    e.redirect.addr = r.pc + 32'($signed({r.ir[31], r.ir[7], r.ir[30:25], r.ir[11:8], 1'b0}));
    e.csr.sel = r.ir[31:20];
    case (r.op)
      OP_ADD: e.rd = r.a + r.b;
      OP_SUB: e.rd = r.a - r.b;
      OP_SLL, OP_SLLI: e.rd = r.a << sh;
      OP_SLT: e.rd = 32'($signed(r.a) < $signed(r.b));
      OP_SLTU: e.rd = 32'(r.a < r.b);
      OP_XOR: e.rd = r.a ^ r.b;
      OP_SRL, OP_SRLI: e.rd = r.a >> sh;
      OP_SRA, OP_SRAI: e.rd = 32'($signed(r.a) >>> sh);
      OP_OR: e.rd = r.a | r.b;
      OP_AND: e.rd = r.a & r.b;
      OP_MUL: e.rd = p_uu[31:0]; // Low half is sign independent
      OP_MULH: e.rd = p_ss[63:32];
      OP_MULHSU: e.rd = p_su[63:32];
      OP_MULHU: e.rd = p_uu[63:32];
      OP_DIV, OP_DIVU, OP_REM, OP_REMU: e.rd = div_model(r);
      OP_ADDI: e.rd = r.a + imm_i;
      OP_SLTI: e.rd = 32'($signed(r.a) < $signed(imm_i));
      OP_SLTIU: e.rd = 32'(r.a < imm_i);
      OP_XORI: e.rd = r.a ^ imm_i;
      OP_ORI: e.rd = r.a | imm_i;
      OP_ANDI: e.rd = r.a & imm_i;
      OP_BEQ: e.redirect.valid = (r.a == r.b);
      OP_BNE: e.redirect.valid = (r.a != r.b);
      OP_BLT: e.redirect.valid = ($signed(r.a) < $signed(r.b));
      OP_BGE: e.redirect.valid = ($signed(r.a) >= $signed(r.b));
      OP_BLTU: e.redirect.valid = (r.a < r.b);
      OP_BGEU: e.redirect.valid = (r.a >= r.b);
      OP_JAL: e.redirect = '{1'b1, r.pc + imm_j};
      OP_JALR: e.redirect = '{1'b1, r.a + imm_i};
      OP_LUI: e.rd = imm_u;
      OP_AUIPC: e.rd = r.pc + imm_u;
      OP_CSRRW: e.csr.data = r.a;
      OP_CSRRS: e.csr.data = old | r.a;
      OP_CSRRC: e.csr.data = old & ~r.a;
      OP_CSRRWI: e.csr.data = zimm;
      OP_CSRRSI: e.csr.data = old | zimm;
      OP_CSRRCI: e.csr.data = old & ~zimm;
      default: ;
    endcase
    if (r.op inside {OP_JAL, OP_JALR}) e.rd = r.pc + 32'd4;
    if (r.op inside {[OP_CSRRW:OP_CSRRCI]}) begin
      e.csr.wr = 1'b1;
      e.rd = old;
    end
    return e;
  endfunction

  function automatic csr_wr_t status_model(input logic is_m, input priv_mode_e mode,
                                           input trap_csrs_t c);
    logic [XLEN-1:0] s;
    if (is_m) begin
      s = c.mstatus;
      s[12:11] = mode; // MPP
      s[7] = c.mstatus[3];
      s[3] = 1'b0;
      return '{1'b1, CSR_MSTATUS, s};
    end
    s = c.sstatus;
    s[8] = mode[0]; // SPP
    s[5] = c.sstatus[1];
    s[1] = 1'b0;
    return '{1'b1, CSR_SSTATUS, s};
  endfunction

  task automatic check_rd(input string name, input logic exp_wr, input logic [XLEN-1:0] exp,
                          input logic act_wr, input logic [XLEN-1:0] act);
    if (exp_wr !== act_wr || (exp_wr && exp !== act)) begin
      $display("[FAIL] %s rd: expected wr=%0b %h, actual wr=%0b %h",
               name, exp_wr, exp, act_wr, act);
      err_cnt++;
    end
  endtask

  task automatic check_redirect(input string name, input redirect_t exp, input redirect_t act);
    if (exp.valid !== act.valid || (exp.valid && exp.addr !== act.addr)) begin
      $display("[FAIL] %s redirect: expected %h, actual %h", name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_csr(input string name, input csr_wr_t exp, input csr_wr_t act);
    if (exp.wr !== act.wr || (exp.wr && (exp.sel !== act.sel || exp.data !== act.data))) begin
      $display("[FAIL] %s csr: expected %h, actual %h", name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("[FAIL] %s trap_done: expected %0b, actual %0b", name, exp, act);
      err_cnt++;
    end
  endtask

  // Comparator wakes at the falling edge when outputs are settled
  initial begin
    forever begin
      @(cmp_ev);
      check_rd(test_name, exp_q.rd_wr, exp_q.rd, rd_wr, rd_data);
      check_redirect(test_name, exp_q.redirect, redirect);
      check_csr(test_name, exp_q.csr, csr);
      check_flag(test_name, exp_q.trap_done, trap_done);
    end
  end

  task automatic drive(input stage_e st, input exec_req_t r, input logic [XLEN-1:0] old);
    @(posedge clk);
    #1;
    stage = st;
    req = r;
    csr_rdata = old;
  endtask

  task automatic compare_now(input string name, input exec_exp_t e);
    test_name = name;
    exp_q = e;
    ->cmp_ev;
  endtask

  task automatic run_op(input exec_op_e op);
    exec_req_t r;
    logic [XLEN-1:0] old;
    r = '{op, rand_bits(32), rand_bits(32), rand_bits(32), rand_bits(32)};
    if (rand_bits(1) != 0) r.b = r.a; // Equal operands half the time
    old = rand_bits(32);
    drive(ST_EXECUTE, r, old);
    @(negedge clk);
    compare_now(op.name(), exec_model(r, old));
  endtask

  task automatic run_div(input exec_op_e op, input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
    exec_req_t r;
    int n;
    r = '{op, rand_bits(32), a, b, rand_bits(32)};
    drive(ST_EXECUTE, r, '0);
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!rd_wr && n < WAIT_LIMIT);
    if (!rd_wr) begin
      $display("Timeout: no result from %s within %0d cycles", op.name(), WAIT_LIMIT);
      timeout_cnt++;
    end else begin
      compare_now(op.name(), exec_model(r, '0));
    end
    drive(ST_FETCH, r, '0);
  endtask

  task automatic run_trap(input logic is_m);
    exec_req_t r;
    exec_exp_t e;
    int n;
    r = '{OP_ADD, rand_bits(32), '0, '0, rand_bits(32)};
    drive(is_m ? ST_MINT : ST_SINT, r, '0);
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!csr.wr && n < WAIT_LIMIT);
    if (!csr.wr) begin
      $display("Timeout: no status write after interrupt entry");
      timeout_cnt++;
    end else begin
      e = '0;
      e.csr = status_model(is_m, tb_mode, trap_csrs);
      compare_now(is_m ? "mint status" : "sint status", e);
      @(negedge clk);
      e.csr = '{1'b1, is_m ? CSR_MEPC : CSR_SEPC, r.pc};
      e.redirect = '{1'b1, is_m ? trap_csrs.mtvec : trap_csrs.stvec};
      e.trap_done = 1'b1;
      compare_now(is_m ? "mint epc" : "sint epc", e);
      tb_mode = is_m ? MODE_MACHINE : MODE_SUPERVISOR;
    end
    drive(ST_FETCH, r, '0);
  endtask

  initial begin
    exec_req_t r;
    lfsr_q = 32'h8ec3_86f0;
    err_cnt = 0;
    timeout_cnt = 0;
    tb_mode = MODE_MACHINE;
    rst_n = 1'b0;
    stage = ST_FETCH;
    req = '0;
    csr_rdata = '0;
    trap_csrs = '{rand_bits(32), rand_bits(32), rand_bits(32) & ~32'h3, rand_bits(32) & ~32'h3};
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;
    for (int k = 0; k < 8; k++) begin
      r = '{exec_op_e'(rand_bits(6) % 60), rand_bits(32), rand_bits(32), rand_bits(32), '0};
      drive(ST_FETCH, r, rand_bits(32));
      @(negedge clk);
      compare_now("fetch idle", '0);
    end
    for (int k = 0; k < 8; k++) begin
      for (int op = 0; op <= int'(OP_CSRRCI); op++) begin
        if (!(op inside {[OP_DIV:OP_REMU], [OP_LB:OP_SW]})) run_op(exec_op_e'(op));
      end
    end
    for (int k = 0; k < 4; k++) begin
      run_div(exec_op_e'(int'(OP_DIV) + k), rand_bits(32), rand_bits(32));
      run_div(exec_op_e'(int'(OP_DIV) + k), rand_bits(32), rand_bits(8));
      run_div(exec_op_e'(int'(OP_DIV) + k), rand_bits(32), '0);
      run_div(exec_op_e'(int'(OP_DIV) + k), 32'h8000_0000, 32'hffff_ffff);
    end
    run_trap(1'b1);
    run_trap(1'b0);
    run_trap(1'b1); // MPP now from supervisor
    drive(ST_FETCH, '0, '0);
    @(negedge clk);
    $display("Error counts: %0d mismatches, %0d timeouts", err_cnt, timeout_cnt);
    if (err_cnt == 0 && timeout_cnt == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: filelist.f
logic/rv_exec_pkg.sv
logic/int_alu.sv
logic/seq_divider.sv
logic/trap_entry.sv
logic/exec_unit.sv
sim/exec_unit_asserts.sv
sim/exec_unit_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS = --binary --timing --assert -Wno-fatal
TOP = exec_unit_tb
FILELIST = filelist.f
LOG = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Checks failed" $(LOG); then exit 1; fi
	@grep -q "All checks passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
